// File: test/pu_div_vectors.txt
# numer numer_attr denom denom_attr quotient remainder invalid, all in hex
# quotient is the raw value before the scaling shift
00000064 0 00000007 0 0000000e 00000002 0
ffffffff 0 00000001 0 ffffffff 00000000 0
ffffffff 0 ffffffff 0 00000001 00000000 0
00000000 0 00001234 0 00000000 00000000 0
12345678 0 00000010 0 01234567 00000008 0
00000005 0 00000009 0 00000000 00000005 0
80000000 0 00000003 0 2aaaaaaa 00000002 0
deadbeef 0 00010000 0 0000dead 0000beef 0
0000abcd 0 00000000 0 ffffffff 0000abcd 1
00000000 0 00000000 0 ffffffff 00000000 1
00000064 1 00000007 0 0000000e 00000002 1
00000064 0 00000007 1 0000000e 00000002 1
00000064 e 00000007 0 0000000e 00000002 0
fffffffe 0 00000002 0 7fffffff 00000000 0
00001000 0 00001001 0 00000000 00001000 0
87654321 0 00000100 0 00876543 00000021 0
0000ffff 3 00000000 2 ffffffff 0000ffff 1
7fffffff 0 80000000 0 00000000 7fffffff 0
c0000000 0 40000000 0 00000003 00000000 0
0001e240 0 0000007b 0 000003eb 00000057 0
00000007 0 00000007 1 00000001 00000000 1
ffffffff 0 00010001 0 0000ffff 00000000 0

// File: project.f
+incdir+hw
hw/pu_pkg.sv
hw/div_pipe.sv
hw/pu_div.sv
hw/pu_cmd_decode.sv
hw/pu_tile.sv
test/pu_tile_asserts.sv
test/pu_tile_tb.sv

// File: run.sh
#!/bin/sh
# build the pu_tile testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module pu_tile_tb -o sim_pu_tile
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_pu_tile)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "TESTS PASSED"; then
    exit 0
fi

echo "pass message not found in the simulation output"
exit 1

// File: test/pu_tile_tb.sv
`timescale 1ns/1ns
`include "pu_config.svh"

module pu_tile_tb
    import pu_pkg::*;
    ();

    localparam int P           = `PU_DIV_PIPELINE;
    localparam int W           = `PU_DATA_WIDTH;
    localparam int INV         = `PU_INVALID_BIT;
    localparam int RAND_COUNT  = 24;
    localparam int BURST_COUNT = 6;

    typedef struct {
        pu_word_t quo;
        pu_word_t rem;
        logic     inv;
    } result_t;

    typedef struct {
        pu_word_t num;
        pu_attr_t num_attr;
        pu_word_t den;
        pu_attr_t den_attr;
        result_t  res;
    } vector_t;

    logic    clk;
    logic    rst;
    pu_cmd_t cmd;
    pu_bus_t bus;
    logic    done;

    vector_t     vecs[$];
    logic [15:0] lfsr;
    bit          loaded;
    int          errors;
    int          tests;
    int          tests_bad;
    longint      timeout_ns;

    pu_tile uut
        ( .clk  (clk)
        , .rst  (rst)
        , .cmd  (cmd)
        , .bus  (bus)
        , .done (done)
        );

    initial begin : clock_gen
        clk = 1'b0;
        forever begin
            #2;
            clk = ~clk;
        end
    end

    // galois form, one step per bit handed out.
    function automatic pu_word_t rand_bits(input int n);
        pu_word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[W-2:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic pu_attr_t rand_attr();
        pu_word_t r;
        pu_attr_t a;
        r = rand_bits(`PU_ATTR_WIDTH);
        a = r[`PU_ATTR_WIDTH-1:0];
        if (rand_bits(2) != '0) begin
            a[INV] = 1'b0; // keep most arguments valid.
        end
        return a;
    endfunction

    function automatic pu_word_t rand_den();
        pu_word_t d;
        pu_word_t sh;
        d  = rand_bits(W);
        sh = rand_bits(5);
        d  = d >> sh; // spread the divisor over all magnitudes.
        if (rand_bits(4) == '0) begin
            d = '0;
        end
        return d;
    endfunction

    function automatic result_t divide_ref(input pu_word_t num, input pu_attr_t num_attr,
                                           input pu_word_t den, input pu_attr_t den_attr);
        result_t r;
        if (den == '0) begin
            r.quo = '1;
            r.rem = num;
        end else begin
            r.quo = num / den;
            r.rem = num % den;
        end
        r.inv = num_attr[INV] | den_attr[INV] | (den == '0);
        return r;
    endfunction

    task automatic send(input pu_op_t op, input pu_word_t data, input pu_attr_t attr);
        cmd.strobe = 1'b1;
        cmd.op     = op;
        cmd.data   = data;
        cmd.attr   = attr;
    endtask

    task automatic send_idle();
        cmd = '0;
    endtask

    task automatic check_word(input string name, input pu_word_t got, input pu_word_t exp);
        if (got !== exp) begin
            $display("Fail %s: expected %h, got %h at %0t ns", name, exp, got, $time);
            errors++;
        end
    endtask

    // bus is combinational from the command, so sample it mid-cycle.
    task automatic check_bus(input result_t exp, input bit rem_sel);
        pu_word_t exp_data;
        pu_attr_t exp_attr;
        string    name;
        exp_attr      = '0;
        exp_attr[INV] = exp.inv;
        if (rem_sel) begin
            exp_data = exp.rem;
            name     = "bus.data (remainder)";
        end else begin
            exp_data = exp.quo << `PU_SCALE_POW;
            name     = "bus.data (quotient)";
        end
        #2;
        check_word(name, bus.data, exp_data);
        check_word("bus.attr", pu_word_t'(bus.attr), pu_word_t'(exp_attr));
    endtask

    task automatic check_idle();
        #2;
        check_word("bus.data", bus.data, '0);
        check_word("bus.attr", pu_word_t'(bus.attr), '0);
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests++;
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_bad++;
            $display("test %s: %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic load_vectors(output bit ok);
        int          fd;
        int          n;
        string       line;
        logic [31:0] f [7];
        vector_t     v;
        ok = 1'b0;
        fd = $fopen("test/pu_div_vectors.txt", "r");
        if (fd == 0) begin
            $display("cannot open the vector file test/pu_div_vectors.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n    = $fgets(line, fd);
                if (n > 0 && line.len() > 0 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h",
                                f[0], f[1], f[2], f[3], f[4], f[5], f[6]);
                    if (n == 7) begin
                        v.num      = f[0];
                        v.num_attr = f[1][`PU_ATTR_WIDTH-1:0];
                        v.den      = f[2];
                        v.den_attr = f[3][`PU_ATTR_WIDTH-1:0];
                        v.res.quo  = f[4];
                        v.res.rem  = f[5];
                        v.res.inv  = f[6][0];
                        vecs.push_back(v);
                    end
                end
            end
            $fclose(fd);
            ok = (vecs.size() > 0);
            if (!ok) begin
                $display("the vector file holds no usable lines");
            end
        end
    endtask

    task automatic wait_done(output bit seen, output int lat);
        seen = 1'b0;
        lat  = 0;
        while (!seen && lat < P + 4) begin
            @(posedge clk);
            #1;
            send_idle();
            lat++;
            if (done) begin
                seen = 1'b1;
            end
        end
    endtask

    task automatic run_reset_test();
        int e0;
        e0 = errors;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        send_idle();
        check_idle();
        check_word("done", pu_word_t'(done), '0);
        @(posedge clk);
        #1;
        check_idle();
        check_word("done", pu_word_t'(done), '0);
        report_test("reset", e0);
    endtask

    task automatic run_vector(input int idx);
        vector_t v;
        int      e0;
        int      lat;
        bit      seen;
        string   name;
        v    = vecs[idx];
        e0   = errors;
        name = $sformatf("vector %0d", idx);
        @(posedge clk);
        #1;
        send(PU_OP_LOAD_NUM, v.num, v.num_attr);
        @(posedge clk);
        #1;
        send(PU_OP_LOAD_DEN, v.den, v.den_attr);
        wait_done(seen, lat);
        if (!seen) begin
            $display("%s: no done strobe within %0d cycles of the launch", name, P + 4);
            errors++;
        end else begin
            if (lat != P + 2) begin
                $display("%s: done came %0d cycles after the launch strobe, expected %0d",
                         name, lat, P + 2);
                errors++;
            end
            send(PU_OP_READ_QUO, '0, '0);
            check_bus(v.res, 1'b0);
            @(posedge clk);
            #1;
            send(PU_OP_READ_REM, '0, '0);
            check_bus(v.res, 1'b1);
            @(posedge clk);
            #1;
            send_idle();
            check_idle();
        end
        report_test(name, e0);
    endtask

    // launches every spacing cycles; a result is read only where the command slot is free.
    task automatic run_stream(input string name, input int count, input int spacing);
        result_t  pending[$];
        result_t  cur;
        pu_word_t num;
        pu_attr_t num_attr;
        pu_word_t den;
        pu_attr_t den_attr;
        int       e0;
        int       issued;
        int       dones;
        int       cyc;
        int       limit;
        bit       have_cur;
        bit       rem_due;
        e0       = errors;
        issued   = 0;
        dones    = 0;
        cyc      = 0;
        limit    = count * spacing + 4 * P + 20;
        num      = '0;
        num_attr = '0;
        rem_due  = 1'b0;
        while ((issued < count || pending.size() > 0 || rem_due) && cyc < limit) begin
            @(posedge clk);
            #1;
            send_idle();
            have_cur = 1'b0;
            if (done) begin
                dones++;
                if (pending.size() == 0) begin
                    $display("done strobe without a division in flight at %0t ns", $time);
                    errors++;
                    rem_due = 1'b0;
                end else begin
                    cur      = pending.pop_front();
                    have_cur = 1'b1;
                    rem_due  = 1'b1;
                end
            end
            if (issued < count && cyc % spacing == 0) begin
                num      = rand_bits(W);
                num_attr = rand_attr();
                send(PU_OP_LOAD_NUM, num, num_attr);
            end else if (issued < count && cyc % spacing == 1) begin
                den      = rand_den();
                den_attr = rand_attr();
                send(PU_OP_LOAD_DEN, den, den_attr);
                pending.push_back(divide_ref(num, num_attr, den, den_attr));
                issued++;
            end else if (have_cur) begin
                send(PU_OP_READ_QUO, '0, '0);
                check_bus(cur, 1'b0);
            end else if (rem_due) begin
                send(PU_OP_READ_REM, '0, '0);
                check_bus(cur, 1'b1);
                rem_due = 1'b0;
            end else begin
                check_idle();
            end
            cyc++;
        end
        if (issued != count || pending.size() != 0) begin
            $display("%s: divisions were still in flight when the stream ended", name);
            errors++;
        end
        if (dones != count) begin
            $display("%s: %0d done strobes for %0d launches", name, dones, count);
            errors++;
        end
        report_test(name, e0);
    endtask

    initial begin : watchdog
        wait (loaded);
        timeout_ns = longint'(vecs.size() + RAND_COUNT + BURST_COUNT) * (P + 8) * 4 + 200;
        #(timeout_ns);
        $display("the run did not finish within %0d ns and was stopped", timeout_ns);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin : main
        bit ok;
        rst       = 1'b1;
        cmd       = '0;
        loaded    = 1'b0;
        errors    = 0;
        tests     = 0;
        tests_bad = 0;
        lfsr      = 16'd19992;
        load_vectors(ok);
        if (!ok) begin
            $display("TESTS FAILED");
            $finish;
        end else begin
            loaded = 1'b1;
            run_reset_test();
            foreach (vecs[i]) begin
                run_vector(i);
            end
            run_stream("overlapped random divisions", RAND_COUNT, 4);
            run_stream("back-to-back random divisions", BURST_COUNT, 2);
            $display("tests run: %0d, tests with errors: %0d, errors: %0d",
                     tests, tests_bad, errors);
            if (errors == 0) begin
                $display("TESTS PASSED");
            end else begin
                $display("TESTS FAILED");
            end
            $finish;
        end
    end

endmodule

// File: test/pu_tile_asserts.sv
`timescale 1ns/1ns
`include "pu_config.svh"

module pu_tile_asserts
    import pu_pkg::*;
    ( input logic     clk
    , input logic     rst
    , input pu_cmd_t  cmd
    , input pu_bus_t  bus
    , input logic     done
    );

    localparam int P = `PU_DIV_PIPELINE;

    logic launch;
    logic read_cmd;

    assign launch   = cmd.strobe && (cmd.op == PU_OP_LOAD_DEN);
    assign read_cmd = cmd.strobe && ((cmd.op == PU_OP_READ_QUO) || (cmd.op == PU_OP_READ_REM));

    // units share the bus by OR, so an unselected unit must drive zero.
    bus_quiet: assert property (@(posedge clk) !read_cmd |-> (bus == '0))
        else $error("bus is not zero while no read command is given");

    no_done_in_reset: assert property (@(posedge clk) (rst && $past(rst)) |-> !done)
        else $error("done is high during reset");

    // done lands one cycle after the result register, P+2 edges after the strobe.
    done_has_launch: assert property (@(posedge clk) disable iff (rst)
        done |-> $past(launch, P + 2))
        else $error("done strobe without a matching denominator load");

endmodule

bind pu_tile pu_tile_asserts u_asserts
    ( .clk  (clk)
    , .rst  (rst)
    , .cmd  (cmd)
    , .bus  (bus)
    , .done (done)
    );

// File: hw/pu_tile.sv
`timescale 1ns/1ns

module pu_tile
    import pu_pkg::*;
    ( input  logic    clk
    , input  logic    rst
    , input  pu_cmd_t cmd
    , output pu_bus_t bus
    , output logic    done
    );

    pu_ctrl_t ctrl; // decoded unit controls.

    pu_cmd_decode u_decode
        ( .clk  (clk)
        , .rst  (rst)
        , .cmd  (cmd)
        , .ctrl (ctrl)
        , .done (done)
        );

    pu_div u_div
        ( .clk  (clk)
        , .rst  (rst)
        , .ctrl (ctrl)
        , .bus  (bus)
        );

endmodule

// File: hw/pu_cmd_decode.sv
`timescale 1ns/1ns
`include "pu_config.svh"

module pu_cmd_decode
    import pu_pkg::*;
    ( input  logic     clk
    , input  logic     rst
    , input  pu_cmd_t  cmd
    , output pu_ctrl_t ctrl
    , output logic     done
    );

    localparam int P = `PU_DIV_PIPELINE;

    logic         launch;
    logic [P:0]   launch_q; // one mark per division in flight.
    logic         done_q;

    always_comb begin
        ctrl      = '0;
        ctrl.data = cmd.data;
        ctrl.attr = cmd.attr;
        if (cmd.strobe) begin
            unique case (cmd.op)
                PU_OP_LOAD_NUM: begin
                    ctrl.wr_en  = 1'b1;
                    ctrl.wr_sel = 1'b0;
                end
                PU_OP_LOAD_DEN: begin
                    ctrl.wr_en  = 1'b1;
                    ctrl.wr_sel = 1'b1;
                end
                PU_OP_READ_QUO: begin
                    ctrl.oe     = 1'b1;
                    ctrl.oe_sel = 1'b0;
                end
                PU_OP_READ_REM: begin
                    ctrl.oe     = 1'b1;
                    ctrl.oe_sel = 1'b1;
                end
            endcase
        end
    end

    assign launch = cmd.strobe && (cmd.op == PU_OP_LOAD_DEN);

    // the last mark lines up with the result register edge, done follows it.
    always_ff @(posedge clk) begin
        if (rst) begin
            launch_q <= '0;
            done_q   <= 1'b0;
        end else begin
            launch_q <= {launch_q[P-1:0], launch};
            done_q   <= launch_q[P];
        end
    end

    assign done = done_q;

endmodule

// File: hw/pu_div.sv
`timescale 1ns/1ns
`include "pu_config.svh"

module pu_div
    import pu_pkg::*;
    ( input  logic     clk
    , input  logic     rst
    , input  pu_ctrl_t ctrl
    , output pu_bus_t  bus
    );

    localparam int P   = `PU_DIV_PIPELINE;
    localparam int INV = `PU_INVALID_BIT;

    typedef struct packed {
        pu_word_t quo;
        pu_word_t rem;
        logic     inv;
    } result_t;

    pu_bus_t  num_latch;  // numerator waiting for its denominator.
    pu_bus_t  arg_num;
    pu_bus_t  arg_den;
    logic     arg_go;     // high the cycle after a launch.
    logic     arg_inv;
    logic [P-1:0] inv_chain;
    logic [P-1:0] go_chain;
    pu_word_t div_quo;
    pu_word_t div_rem;
    result_t  res;

    always_ff @(posedge clk) begin
        if (rst) begin
            num_latch <= '0;
            arg_num   <= '0;
            arg_den   <= '0;
            arg_go    <= 1'b0;
        end else begin
            arg_go <= ctrl.wr_en && ctrl.wr_sel;
            if (ctrl.wr_en && !ctrl.wr_sel) begin
                num_latch.data <= ctrl.data;
                num_latch.attr <= ctrl.attr;
            end else if (ctrl.wr_en && ctrl.wr_sel) begin
                arg_num      <= num_latch;
                arg_den.data <= ctrl.data;
                arg_den.attr <= ctrl.attr;
            end
        end
    end

    assign arg_inv = arg_num.attr[INV] || arg_den.attr[INV] || (arg_den.data == '0);

    // keeps the flag and the launch mark in step with the divider stages.
    always_ff @(posedge clk) begin
        if (rst) begin
            inv_chain <= '0;
            go_chain  <= '0;
        end else begin
            inv_chain <= {inv_chain[P-2:0], arg_inv};
            go_chain  <= {go_chain[P-2:0], arg_go};
        end
    end

    div_pipe u_div_pipe
        ( .clk      (clk)
        , .rst      (rst)
        , .numer    (arg_num.data)
        , .denom    (arg_den.data)
        , .quotient (div_quo)
        , .remain   (div_rem)
        );

    always_ff @(posedge clk) begin
        if (rst) begin
            res <= '0;
        end else if (go_chain[P-1]) begin
            res.quo <= div_quo;
            res.rem <= div_rem;
            res.inv <= inv_chain[P-1];
        end
    end

    // zero when not selected so several units can share the bus by OR.
    always_comb begin
        bus = '0;
        if (ctrl.oe) begin
            bus.data      = ctrl.oe_sel ? res.rem : (res.quo << `PU_SCALE_POW);
            bus.attr[INV] = res.inv;
        end
    end

endmodule

// File: hw/div_pipe.sv
`timescale 1ns/1ns
`include "pu_config.svh"

module div_pipe
    import pu_pkg::*;
    ( input  logic     clk
    , input  logic     rst
    , input  pu_word_t numer
    , input  pu_word_t denom
    , output pu_word_t quotient
    , output pu_word_t remain
    );

    localparam int W = `PU_DATA_WIDTH;
    localparam int P = `PU_DIV_PIPELINE;
    localparam int K = W / P; // quotient bits resolved per stage.

    if ((P < 2) || (P % 2 != 0) || (W % P != 0)) begin : g_bad_cfg
        $error("div_pipe: pipeline depth must be even, at least 2, and divide the width");
    end

    // state carried from stage to stage. quo holds the numerator bits still to be
    // shifted in at the top and the quotient bits already resolved at the bottom.
    typedef struct packed {
        pu_word_t rem;
        pu_word_t quo;
        pu_word_t den;
    } stage_t;

    stage_t stage_first;
    stage_t stage_q [P];

    // K restoring steps, shift one numerator bit in and subtract when it fits.
    function automatic stage_t div_steps(stage_t s);
        logic [W:0] trial;
        stage_t     r;
        r = s;
        for (int i = 0; i < K; i++) begin
            trial = {r.rem, r.quo[W-1]};
            r.quo = {r.quo[W-2:0], 1'b0};
            if (trial >= {1'b0, r.den}) begin
                trial    = trial - {1'b0, r.den};
                r.quo[0] = 1'b1;
            end
            r.rem = trial[W-1:0];
        end
        return r;
    endfunction

    always_comb begin
        stage_first.rem = '0;
        stage_first.quo = numer;
        stage_first.den = denom;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < P; s++) begin
                stage_q[s] <= '0;
            end
        end else begin
            stage_q[0] <= div_steps(stage_first);
            for (int s = 1; s < P; s++) begin
                stage_q[s] <= div_steps(stage_q[s-1]);
            end
        end
    end

    // a zero divisor always fits, so every quotient bit comes out set
    // and the numerator ends up whole in the remainder.
    assign quotient = stage_q[P-1].quo;
    assign remain   = stage_q[P-1].rem;

endmodule

// File: hw/pu_pkg.sv
`include "pu_config.svh"

package pu_pkg;

    typedef logic [`PU_DATA_WIDTH-1:0] pu_word_t;
    typedef logic [`PU_ATTR_WIDTH-1:0] pu_attr_t;

    typedef enum logic [1:0] {
        PU_OP_LOAD_NUM = 2'd0,
        PU_OP_LOAD_DEN = 2'd1,
        PU_OP_READ_QUO = 2'd2,
        PU_OP_READ_REM = 2'd3
    } pu_op_t;

    // one command from the sequencer.
    typedef struct packed {
        logic     strobe; // high for one cycle per command.
        pu_op_t   op;
        pu_word_t data;
        pu_attr_t attr;
    } pu_cmd_t;

    typedef struct packed {
        logic     wr_en;
        logic     wr_sel; // 0 numerator, 1 denominator.
        logic     oe;
        logic     oe_sel; // 0 quotient, 1 remainder.
        pu_word_t data;
        pu_attr_t attr;
    } pu_ctrl_t;

    typedef struct packed {
        pu_word_t data;
        pu_attr_t attr;
    } pu_bus_t;

endpackage

// File: hw/pu_config.svh
`ifndef PU_CONFIG_SVH
`define PU_CONFIG_SVH

`define PU_DATA_WIDTH   32 // bits per data word.
`define PU_ATTR_WIDTH   4  // attribute bits beside each word.
`define PU_INVALID_BIT  0  // position of the invalid flag in the attribute.

// keep even and at least 2, and a divisor of the data width.
`define PU_DIV_PIPELINE 4

`define PU_SCALE_POW    0  // quotient is shifted left by this on read.

`endif
